//--- common/rv32_bus_pkg.sv
`default_nettype none

`include "rv32_defs.svh"

package rv32_bus_pkg;

    typedef enum logic [1:0] {
        IDLE,
        REQ,
        WAIT_ACK,
        HOLD
    } fetch_state_e;

    // read-only wishbone master request
    typedef struct packed {
        logic                  cyc;
        logic                  stb;
        logic [`RV32_XLEN-1:0] adr;
    } wb_req_t;

endpackage

`default_nettype wire

//--- common/rv32_defs.svh
`ifndef RV32_DEFS_SVH
`define RV32_DEFS_SVH

// data and address width
`define RV32_XLEN 32

// architectural register count
`define RV32_NR_REGS 32

// register index width
`define RV32_REG_IDX_W 5

// first fetch address after reset
`define RV32_RESET_PC 32'h20400000

// pc increment per instruction
`define RV32_INSTR_BYTES 32'd4

`endif

//--- common/rv32_isa_pkg.sv
`default_nettype none

`include "rv32_defs.svh"

package rv32_isa_pkg;

    // supported major opcodes
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_OP_IMM = 7'b0010011
    } opcode_e;

    typedef enum logic [2:0] {
        F3_BEQ  = 3'b000,
        F3_BNE  = 3'b001,
        F3_BLT  = 3'b100,
        F3_BGE  = 3'b101,
        F3_BLTU = 3'b110,
        F3_BGEU = 3'b111
    } branch_f3_e;

    // SRLI and SRAI share 101, bit 30 picks one
    typedef enum logic [2:0] {
        F3_ADDI  = 3'b000,
        F3_SLLI  = 3'b001,
        F3_SLTI  = 3'b010,
        F3_SLTIU = 3'b011,
        F3_XORI  = 3'b100,
        F3_SRXI  = 3'b101,
        F3_ORI   = 3'b110,
        F3_ANDI  = 3'b111
    } opimm_f3_e;

    typedef struct packed {
        logic                       valid;
        logic [`RV32_XLEN-1:0]      pc;
        opcode_e                    opcode;
        logic [2:0]                 funct3;
        logic                       arith;
        logic [`RV32_REG_IDX_W-1:0] rs1;
        logic [`RV32_REG_IDX_W-1:0] rs2;
        logic [`RV32_REG_IDX_W-1:0] rd;
        logic [`RV32_XLEN-1:0]      imm;
        logic                       known;
    } decoded_t;

    typedef struct packed {
        logic                       valid;
        logic [`RV32_XLEN-1:0]      pc;
        logic                       we;
        logic [`RV32_REG_IDX_W-1:0] rd;
        logic [`RV32_XLEN-1:0]      wdata;
        logic [`RV32_XLEN-1:0]      next_pc;
    } retire_t;

endpackage

`default_nettype wire

//--- design/rv32_core_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "rv32_defs.svh"

module rv32_core_top (
    input  wire                   i_clk,
    input  wire                   i_rst,
    input  wire [`RV32_XLEN-1:0]  i_data,
    input  wire                   i_ack,
    input  wire                   i_stall,
    output rv32_bus_pkg::wb_req_t o_wb,
    output rv32_isa_pkg::retire_t o_retire
);

    logic [`RV32_XLEN-1:0]      instr;
    logic [`RV32_XLEN-1:0]      instr_pc;
    logic                       instr_valid;
    rv32_isa_pkg::decoded_t     dec;
    logic [`RV32_XLEN-1:0]      rs1_data;
    logic [`RV32_XLEN-1:0]      rs2_data;
    logic                       rd_we;
    logic [`RV32_REG_IDX_W-1:0] rd_addr;
    logic [`RV32_XLEN-1:0]      rd_wdata;
    logic                       redirect;
    logic [`RV32_XLEN-1:0]      redirect_pc;

    rv32_fetch_unit u_fetch (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_data        (i_data),
        .i_ack         (i_ack),
        .i_stall       (i_stall),
        .i_redirect    (redirect),
        .i_redirect_pc (redirect_pc),
        .o_wb          (o_wb),
        .o_instr       (instr),
        .o_instr_pc    (instr_pc),
        .o_instr_valid (instr_valid)
    );

    rv32_decoder u_decoder (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_instr       (instr),
        .i_instr_pc    (instr_pc),
        .i_instr_valid (instr_valid),
        .o_dec         (dec)
    );

    rv32_execute u_execute (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_dec         (dec),
        .i_rs1_data    (rs1_data),
        .i_rs2_data    (rs2_data),
        .o_rd_we       (rd_we),
        .o_rd_addr     (rd_addr),
        .o_rd_wdata    (rd_wdata),
        .o_redirect    (redirect),
        .o_redirect_pc (redirect_pc),
        .o_retire      (o_retire)
    );

    rv32_regfile u_regfile (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_rs1_addr (dec.rs1),
        .i_rs2_addr (dec.rs2),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data),
        .i_we       (rd_we),
        .i_wr_addr  (rd_addr),
        .i_wr_data  (rd_wdata)
    );

endmodule

`default_nettype wire

//--- design/rv32_decoder.sv
`timescale 1ns/100ps
`default_nettype none

`include "rv32_defs.svh"

module rv32_decoder (
    input  wire                    i_clk,
    input  wire                    i_rst,
    input  wire [`RV32_XLEN-1:0]   i_instr,
    input  wire [`RV32_XLEN-1:0]   i_instr_pc,
    input  wire                    i_instr_valid,
    output rv32_isa_pkg::decoded_t o_dec
);

    rv32_isa_pkg::opcode_e opc;
    logic [`RV32_XLEN-1:0] imm;
    logic                  known;

    assign opc = rv32_isa_pkg::opcode_e'(i_instr[6:0]);

    // format select and immediate build
    always_comb begin
        imm   = '0;
        known = 1'b0;
        case (opc)
            rv32_isa_pkg::OPC_LUI, rv32_isa_pkg::OPC_AUIPC: begin
                imm   = {i_instr[31:12], 12'b0};
                known = 1'b1;
            end
            rv32_isa_pkg::OPC_JAL: begin
                imm   = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12], i_instr[20],
                         i_instr[30:21], 1'b0};
                known = 1'b1;
            end
            rv32_isa_pkg::OPC_JALR: begin
                imm   = {{20{i_instr[31]}}, i_instr[31:20]};
                known = (i_instr[14:12] == 3'b000);
            end
            rv32_isa_pkg::OPC_BRANCH: begin
                imm   = {{19{i_instr[31]}}, i_instr[31], i_instr[7], i_instr[30:25],
                         i_instr[11:8], 1'b0};
                // 010 and 011 are not branch conditions
                known = (i_instr[14:13] != 2'b01);
            end
            rv32_isa_pkg::OPC_OP_IMM: begin
                imm = {{20{i_instr[31]}}, i_instr[31:20]};
                case (i_instr[14:12])
                    3'b001:  known = (i_instr[31:25] == 7'b0);
                    3'b101:  known = !i_instr[31] && (i_instr[29:25] == 5'b0);
                    default: known = 1'b1;
                endcase
            end
            default: known = 1'b0;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_dec.valid <= 1'b0;
        end else begin
            o_dec.valid <= i_instr_valid;
            if (i_instr_valid) begin
                o_dec.pc     <= i_instr_pc;
                o_dec.opcode <= opc;
                o_dec.funct3 <= i_instr[14:12];
                o_dec.arith  <= i_instr[30];
                o_dec.rs1    <= i_instr[19:15];
                o_dec.rs2    <= i_instr[24:20];
                o_dec.rd     <= i_instr[11:7];
                o_dec.imm    <= imm;
                o_dec.known  <= known;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/rv32_execute.sv
`timescale 1ns/100ps
`default_nettype none

`include "rv32_defs.svh"

module rv32_execute (
    input  wire                          i_clk,
    input  wire                          i_rst,
    input  wire rv32_isa_pkg::decoded_t  i_dec,
    input  wire  [`RV32_XLEN-1:0]        i_rs1_data,
    input  wire  [`RV32_XLEN-1:0]        i_rs2_data,
    output logic                         o_rd_we,
    output logic [`RV32_REG_IDX_W-1:0]   o_rd_addr,
    output logic [`RV32_XLEN-1:0]        o_rd_wdata,
    output logic                         o_redirect,
    output logic [`RV32_XLEN-1:0]        o_redirect_pc,
    output rv32_isa_pkg::retire_t        o_retire
);

    logic [`RV32_XLEN-1:0] pc_plus4;
    logic [`RV32_XLEN-1:0] pc_imm;
    logic [`RV32_XLEN-1:0] opimm_res;
    logic [`RV32_XLEN-1:0] wdata;
    logic [`RV32_XLEN-1:0] next_pc;
    logic [4:0]            shamt;
    logic                  taken;
    logic                  writes;

    assign pc_plus4 = i_dec.pc + `RV32_INSTR_BYTES;
    assign pc_imm   = i_dec.pc + i_dec.imm;
    assign shamt    = i_dec.rs2;

    always_comb begin
        case (rv32_isa_pkg::opimm_f3_e'(i_dec.funct3))
            rv32_isa_pkg::F3_ADDI:  opimm_res = i_rs1_data + i_dec.imm;
            rv32_isa_pkg::F3_SLTI:  opimm_res = {31'b0, $signed(i_rs1_data) < $signed(i_dec.imm)};
            rv32_isa_pkg::F3_SLTIU: opimm_res = {31'b0, i_rs1_data < i_dec.imm};
            rv32_isa_pkg::F3_XORI:  opimm_res = i_rs1_data ^ i_dec.imm;
            rv32_isa_pkg::F3_ORI:   opimm_res = i_rs1_data | i_dec.imm;
            rv32_isa_pkg::F3_ANDI:  opimm_res = i_rs1_data & i_dec.imm;
            rv32_isa_pkg::F3_SLLI:  opimm_res = i_rs1_data << shamt;
            default: begin
                // srai when bit 30 set
                if (i_dec.arith) begin
                    opimm_res = $unsigned($signed(i_rs1_data) >>> shamt);
                end else begin
                    opimm_res = i_rs1_data >> shamt;
                end
            end
        endcase
    end

    always_comb begin
        case (rv32_isa_pkg::branch_f3_e'(i_dec.funct3))
            rv32_isa_pkg::F3_BEQ:  taken = (i_rs1_data == i_rs2_data);
            rv32_isa_pkg::F3_BNE:  taken = (i_rs1_data != i_rs2_data);
            rv32_isa_pkg::F3_BLT:  taken = $signed(i_rs1_data) < $signed(i_rs2_data);
            rv32_isa_pkg::F3_BGE:  taken = $signed(i_rs1_data) >= $signed(i_rs2_data);
            rv32_isa_pkg::F3_BLTU: taken = i_rs1_data < i_rs2_data;
            rv32_isa_pkg::F3_BGEU: taken = i_rs1_data >= i_rs2_data;
            default:               taken = 1'b0;
        endcase
    end

    // result and next pc per opcode
    always_comb begin
        wdata   = pc_plus4;
        next_pc = pc_plus4;
        writes  = 1'b1;
        case (i_dec.opcode)
            rv32_isa_pkg::OPC_LUI:    wdata = i_dec.imm;
            rv32_isa_pkg::OPC_AUIPC:  wdata = pc_imm;
            rv32_isa_pkg::OPC_JAL:    next_pc = pc_imm;
            rv32_isa_pkg::OPC_JALR:   next_pc = (i_rs1_data + i_dec.imm) & ~32'd1;
            rv32_isa_pkg::OPC_OP_IMM: wdata = opimm_res;
            rv32_isa_pkg::OPC_BRANCH: begin
                writes = 1'b0;
                if (taken) begin
                    next_pc = pc_imm;
                end
            end
            default: writes = 1'b0;
        endcase
        // unknown encodings just step to pc+4
        if (!i_dec.known) begin
            writes  = 1'b0;
            next_pc = pc_plus4;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_retire.valid <= 1'b0;
        end else begin
            o_retire.valid <= i_dec.valid;
            if (i_dec.valid) begin
                o_retire.pc      <= i_dec.pc;
                o_retire.we      <= writes && (i_dec.rd != '0);
                o_retire.rd      <= i_dec.rd;
                o_retire.wdata   <= wdata;
                o_retire.next_pc <= next_pc;
            end
        end
    end

    assign o_rd_we       = o_retire.valid && o_retire.we;
    assign o_rd_addr     = o_retire.rd;
    assign o_rd_wdata    = o_retire.wdata;
    assign o_redirect    = o_retire.valid;
    assign o_redirect_pc = o_retire.next_pc;

endmodule

`default_nettype wire

//--- design/rv32_fetch_unit.sv
`timescale 1ns/100ps
`default_nettype none

`include "rv32_defs.svh"

module rv32_fetch_unit (
    input  wire                          i_clk,
    input  wire                          i_rst,
    input  wire  [`RV32_XLEN-1:0]        i_data,
    input  wire                          i_ack,
    input  wire                          i_stall,
    input  wire                          i_redirect,
    input  wire  [`RV32_XLEN-1:0]        i_redirect_pc,
    output rv32_bus_pkg::wb_req_t        o_wb,
    output logic [`RV32_XLEN-1:0]        o_instr,
    output logic [`RV32_XLEN-1:0]        o_instr_pc,
    output logic                         o_instr_valid
);

    rv32_bus_pkg::fetch_state_e state;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state         <= rv32_bus_pkg::IDLE;
            o_wb.cyc      <= 1'b0;
            o_wb.stb      <= 1'b0;
            o_instr_valid <= 1'b0;
        end else begin
            o_instr_valid <= 1'b0;
            case (state)
                rv32_bus_pkg::IDLE: begin
                    o_wb.cyc <= 1'b1;
                    o_wb.stb <= 1'b1;
                    o_wb.adr <= `RV32_RESET_PC;
                    state    <= rv32_bus_pkg::REQ;
                end
                rv32_bus_pkg::REQ: begin
                    // request taken when not stalled
                    if (!i_stall) begin
                        o_wb.stb <= 1'b0;
                        state    <= rv32_bus_pkg::WAIT_ACK;
                    end
                end
                rv32_bus_pkg::WAIT_ACK: begin
                    if (i_ack) begin
                        o_wb.cyc      <= 1'b0;
                        o_instr       <= i_data;
                        o_instr_pc    <= o_wb.adr;
                        o_instr_valid <= 1'b1;
                        state         <= rv32_bus_pkg::HOLD;
                    end
                end
                rv32_bus_pkg::HOLD: begin
                    // wait for execute to resolve the next pc
                    if (i_redirect) begin
                        o_wb.cyc <= 1'b1;
                        o_wb.stb <= 1'b1;
                        o_wb.adr <= i_redirect_pc;
                        state    <= rv32_bus_pkg::REQ;
                    end
                end
                default: state <= rv32_bus_pkg::IDLE;
            endcase
        end
    end

    a_stb_needs_cyc: assert property (@(posedge i_clk) disable iff (i_rst)
        o_wb.stb |-> o_wb.cyc);

    a_adr_held_in_stall: assert property (@(posedge i_clk) disable iff (i_rst)
        (o_wb.stb && i_stall) |=> (o_wb.stb && $stable(o_wb.adr)));

    a_no_stb_in_hold: assert property (@(posedge i_clk) disable iff (i_rst)
        (state == rv32_bus_pkg::HOLD) |-> !o_wb.stb);

endmodule

`default_nettype wire

//--- design/rv32_regfile.sv
`timescale 1ns/100ps
`default_nettype none

`include "rv32_defs.svh"

module rv32_regfile (
    input  wire                        i_clk,
    input  wire                        i_rst,
    input  wire  [`RV32_REG_IDX_W-1:0] i_rs1_addr,
    input  wire  [`RV32_REG_IDX_W-1:0] i_rs2_addr,
    output logic [`RV32_XLEN-1:0]      o_rs1_data,
    output logic [`RV32_XLEN-1:0]      o_rs2_data,
    input  wire                        i_we,
    input  wire  [`RV32_REG_IDX_W-1:0] i_wr_addr,
    input  wire  [`RV32_XLEN-1:0]      i_wr_data
);

    logic [`RV32_XLEN-1:0] regs [`RV32_NR_REGS];

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 0; i < `RV32_NR_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && (i_wr_addr != '0)) begin
            regs[i_wr_addr] <= i_wr_data;
        end
    end

    // x0 reads as zero
    assign o_rs1_data = (i_rs1_addr == '0) ? '0 : regs[i_rs1_addr];
    assign o_rs2_data = (i_rs2_addr == '0) ? '0 : regs[i_rs2_addr];

    a_no_x0_write: assert property (@(posedge i_clk) disable iff (i_rst)
        i_we |-> (i_wr_addr != '0));

endmodule

`default_nettype wire

//--- dv/rv32_core_checker.sv
`timescale 1ns/100ps
`default_nettype none

`include "rv32_defs.svh"

module rv32_core_checker #(
    parameter int N_ROWS = 1
) (
    input  wire                        i_clk,
    input  wire                        i_rst,
    input  wire rv32_bus_pkg::wb_req_t i_wb,
    input  wire                        i_stall,
    input  wire                        i_ack,
    input  wire rv32_isa_pkg::retire_t i_retire,
    input  wire rv32_isa_pkg::retire_t i_exp [N_ROWS],
    output logic                       o_done,
    output int                         o_pass_count,
    output int                         o_fail_count,
    output int                         o_bus_errors
);

    int                    row = 0;
    int                    req = 0;
    int                    cycle = 0;
    int                    ack_cycle = 0;
    int                    pass_n = 0;
    int                    fail_n = 0;
    int                    err_n = 0;
    logic                  rst_q = 1'b0;
    logic                  held_q = 1'b0;
    logic                  retire_q = 1'b0;
    logic [`RV32_XLEN-1:0] adr_q = '0;
    logic                  row_bad;

    initial begin
        o_done       = 1'b0;
        o_pass_count = 0;
        o_fail_count = 0;
        o_bus_errors = 0;
    end

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] expv);
        if (got !== expv) begin
            $display("Mismatch at %0t: row %0d %s is %h, expected %h",
                     $time, row, name, got, expv);
            row_bad = 1'b1;
        end
    endtask

    // accepted fetch address follows the previous row's next_pc
    task automatic check_fetch_addr();
        logic [31:0] expv;
        if (req <= N_ROWS) begin
            if (req == 0) begin
                expv = `RV32_RESET_PC;
            end else begin
                expv = i_exp[req-1].next_pc;
            end
            if (i_wb.adr !== expv) begin
                $display("Mismatch at %0t: fetch %0d adr is %h, expected %h",
                         $time, req, i_wb.adr, expv);
                err_n = err_n + 1;
            end
        end
        req = req + 1;
    endtask

    task automatic check_retire();
        if (row >= N_ROWS) begin
            $display("instruction at pc %h retired after the end of the program table",
                     i_retire.pc);
            err_n = err_n + 1;
        end else begin
            row_bad = 1'b0;
            // valid is set two edges after the ack edge and seen one sample later
            if (cycle - ack_cycle != 3) begin
                $display("row %0d retired %0d edges after its ack, expected 2",
                         row, cycle - ack_cycle - 1);
                row_bad = 1'b1;
            end
            compare_field("pc", i_retire.pc, i_exp[row].pc);
            compare_field("we", {31'b0, i_retire.we}, {31'b0, i_exp[row].we});
            if (i_exp[row].we) begin
                compare_field("rd", {27'b0, i_retire.rd}, {27'b0, i_exp[row].rd});
                compare_field("wdata", i_retire.wdata, i_exp[row].wdata);
            end
            compare_field("next_pc", i_retire.next_pc, i_exp[row].next_pc);
            if (row_bad) begin
                fail_n = fail_n + 1;
            end else begin
                pass_n = pass_n + 1;
            end
            $display("row %2d pc %h: %s", row, i_retire.pc, row_bad ? "bad" : "ok");
            row = row + 1;
        end
    endtask

    always @(posedge i_clk) begin
        cycle = cycle + 1;
        if (rst_q && ({i_wb.cyc, i_wb.stb, i_retire.valid} !== 3'b000)) begin
            $display("Mismatch at %0t: cyc/stb/retire valid are %b under reset, expected 000",
                     $time, {i_wb.cyc, i_wb.stb, i_retire.valid});
            err_n = err_n + 1;
        end
        if (!i_rst) begin
            if (held_q && (!i_wb.stb || i_wb.adr !== adr_q)) begin
                $display("Mismatch at %0t: stalled request moved, stb %b adr %h, expected adr %h",
                         $time, i_wb.stb, i_wb.adr, adr_q);
                err_n = err_n + 1;
            end
            if (retire_q && !i_wb.stb) begin
                $display("no fetch request in the cycle after a retire, at time %0t", $time);
                err_n = err_n + 1;
            end
            if (i_wb.stb && !i_stall) begin
                check_fetch_addr();
            end
            if (i_ack && i_wb.cyc) begin
                ack_cycle = cycle;
            end
            if (i_retire.valid) begin
                check_retire();
            end
        end
        rst_q    = i_rst;
        held_q   = !i_rst && i_wb.stb && i_stall;
        adr_q    = i_wb.adr;
        retire_q = !i_rst && i_retire.valid;
        o_done       <= (row >= N_ROWS);
        o_pass_count <= pass_n;
        o_fail_count <= fail_n;
        o_bus_errors <= err_n;
    end

endmodule

`default_nettype wire

//--- dv/tb_rv32_core.sv
`timescale 1ns/100ps
`default_nettype none

`include "rv32_defs.svh"

module tb_rv32_core;

    localparam int          N_ROWS     = 34;
    localparam int          MAX_CYCLES = N_ROWS * 12 + 50;
    localparam logic [31:0] BASE       = `RV32_RESET_PC;
    localparam logic [6:0]  OPI        = 7'b0010011;
    localparam logic [6:0]  LUI        = 7'b0110111;
    localparam logic [6:0]  AUIPC      = 7'b0010111;
    localparam logic [6:0]  JALR       = 7'b1100111;

    logic                  i_clk;
    logic                  i_rst;
    logic [`RV32_XLEN-1:0] i_data;
    logic                  i_ack;
    logic                  i_stall;
    rv32_bus_pkg::wb_req_t o_wb;
    rv32_isa_pkg::retire_t o_retire;

    rv32_isa_pkg::retire_t exp_rows [N_ROWS];
    logic [31:0]           words [N_ROWS];
    logic [31:0]           mem [logic [31:0]];
    logic [31:0]           lcg_state;
    logic [31:0]           req_adr;
    int                    n_loaded = 0;
    int                    cycles = 0;
    int                    mem_errors = 0;
    int                    stall_left = 0;
    int                    ack_wait = 0;
    logic                  pending = 1'b0;
    logic                  stall_set = 1'b0;
    logic                  timed_out = 1'b0;
    logic                  done;
    int                    pass_count;
    int                    fail_count;
    int                    bus_errors;

    rv32_core_top UUT (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_data   (i_data),
        .i_ack    (i_ack),
        .i_stall  (i_stall),
        .o_wb     (o_wb),
        .o_retire (o_retire)
    );

    rv32_core_checker #(.N_ROWS(N_ROWS)) u_checker (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_wb         (o_wb),
        .i_stall      (i_stall),
        .i_ack        (i_ack),
        .i_retire     (o_retire),
        .i_exp        (exp_rows),
        .o_done       (done),
        .o_pass_count (pass_count),
        .o_fail_count (fail_count),
        .o_bus_errors (bus_errors)
    );

    initial i_clk = 1'b0;
    always #4 i_clk = ~i_clk;

    always @(posedge i_clk) cycles <= cycles + 1;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // rv32i instruction formats
    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs1,
                                          input logic [4:0] rs2, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    task automatic add_row(input logic [31:0] off, input logic [31:0] word,
                           input logic [4:0] rd, input logic we,
                           input logic [31:0] wdata, input logic [31:0] next_off);
        words[n_loaded]            = word;
        exp_rows[n_loaded].valid   = 1'b1;
        exp_rows[n_loaded].pc      = BASE + off;
        exp_rows[n_loaded].we      = we;
        exp_rows[n_loaded].rd      = rd;
        exp_rows[n_loaded].wdata   = wdata;
        exp_rows[n_loaded].next_pc = BASE + next_off;
        n_loaded = n_loaded + 1;
    endtask

    // rows in retire order: pc offset, word, rd, we, wdata, next pc offset
    task automatic load_program();
        // x1 = 5 and x2 = -3 feed the branches further down
        add_row('h00, enc_i(12'd5, 5'd0, 3'd0, 5'd1, OPI), 5'd1, 1'b1, 32'd5, 'h04);
        add_row('h04, enc_i(12'hffd, 5'd0, 3'd0, 5'd2, OPI), 5'd2, 1'b1, 32'hfffffffd, 'h08);
        add_row('h08, enc_i(12'd1, 5'd2, 3'd2, 5'd3, OPI), 5'd3, 1'b1, 32'd1, 'h0c);
        add_row('h0c, enc_i(12'd1, 5'd2, 3'd3, 5'd4, OPI), 5'd4, 1'b1, 32'd0, 'h10);
        add_row('h10, enc_i(12'hfff, 5'd1, 3'd4, 5'd5, OPI), 5'd5, 1'b1, 32'hfffffffa, 'h14);
        add_row('h14, enc_i(12'h0f0, 5'd1, 3'd6, 5'd6, OPI), 5'd6, 1'b1, 32'h000000f5, 'h18);
        add_row('h18, enc_i(12'h0ff, 5'd2, 3'd7, 5'd7, OPI), 5'd7, 1'b1, 32'h000000fd, 'h1c);
        add_row('h1c, enc_i(12'd4, 5'd1, 3'd1, 5'd8, OPI), 5'd8, 1'b1, 32'h00000050, 'h20);
        add_row('h20, enc_i(12'd28, 5'd2, 3'd5, 5'd9, OPI), 5'd9, 1'b1, 32'h0000000f, 'h24);
        add_row('h24, enc_i(12'h401, 5'd2, 3'd5, 5'd10, OPI), 5'd10, 1'b1, 32'hfffffffe, 'h28);
        add_row('h28, enc_u(20'h12345, 5'd11, LUI), 5'd11, 1'b1, 32'h12345000, 'h2c);
        add_row('h2c, enc_u(20'h00001, 5'd12, AUIPC), 5'd12, 1'b1, 32'h2040102c, 'h30);
        add_row('h30, enc_u(20'habcde, 5'd0, LUI), 5'd0, 1'b0, 32'd0, 'h34);
        add_row('h34, enc_i(12'd7, 5'd0, 3'd0, 5'd13, OPI), 5'd13, 1'b1, 32'd7, 'h38);
        // each branch is +8, so a taken one skips a word
        add_row('h38, enc_b(13'd8, 5'd1, 5'd1, 3'd0), 5'd0, 1'b0, 32'd0, 'h40);
        add_row('h40, enc_b(13'd8, 5'd1, 5'd2, 3'd0), 5'd0, 1'b0, 32'd0, 'h44);
        add_row('h44, enc_b(13'd8, 5'd1, 5'd2, 3'd1), 5'd0, 1'b0, 32'd0, 'h4c);
        add_row('h4c, enc_b(13'd8, 5'd1, 5'd1, 3'd1), 5'd0, 1'b0, 32'd0, 'h50);
        add_row('h50, enc_b(13'd8, 5'd2, 5'd1, 3'd4), 5'd0, 1'b0, 32'd0, 'h58);
        add_row('h58, enc_b(13'd8, 5'd1, 5'd2, 3'd4), 5'd0, 1'b0, 32'd0, 'h5c);
        add_row('h5c, enc_b(13'd8, 5'd1, 5'd2, 3'd5), 5'd0, 1'b0, 32'd0, 'h64);
        add_row('h64, enc_b(13'd8, 5'd2, 5'd1, 3'd5), 5'd0, 1'b0, 32'd0, 'h68);
        add_row('h68, enc_b(13'd8, 5'd1, 5'd2, 3'd6), 5'd0, 1'b0, 32'd0, 'h70);
        add_row('h70, enc_b(13'd8, 5'd2, 5'd1, 3'd6), 5'd0, 1'b0, 32'd0, 'h74);
        add_row('h74, enc_b(13'd8, 5'd2, 5'd1, 3'd7), 5'd0, 1'b0, 32'd0, 'h7c);
        add_row('h7c, enc_b(13'd8, 5'd1, 5'd2, 3'd7), 5'd0, 1'b0, 32'd0, 'h80);
        add_row('h80, enc_j(21'h20, 5'd14), 5'd14, 1'b1, 32'h20400084, 'ha0);
        add_row('ha0, enc_i(12'h011, 5'd14, 3'd0, 5'd15, JALR), 5'd15, 1'b1, 32'h204000a4, 'h94);
        // custom-0 opcode, not part of rv32i
        add_row('h94, 32'h0000058b, 5'd11, 1'b0, 32'd0, 'h98);
        add_row('h98, enc_j(21'h30, 5'd16), 5'd16, 1'b1, 32'h2040009c, 'hc8);
        add_row('hc8, enc_j(21'h1fffc0, 5'd0), 5'd0, 1'b0, 32'd0, 'h88);
        add_row('h88, enc_i(12'hfe9, 5'd15, 3'd0, 5'd17, JALR), 5'd17, 1'b1, 32'h2040008c, 'h8c);
        add_row('h8c, enc_i(12'd1, 5'd17, 3'd0, 5'd18, OPI), 5'd18, 1'b1, 32'h2040008d, 'h90);
        // parks the core in a loop on itself
        add_row('h90, enc_j(21'd0, 5'd0), 5'd0, 1'b0, 32'd0, 'h90);
    endtask

    function automatic logic [31:0] read_word(input logic [31:0] adr);
        logic [31:0] word;
        if (mem.exists(adr)) begin
            word = mem[adr];
        end else begin
            $display("memory responder got a fetch from %h, outside the program table", adr);
            mem_errors = mem_errors + 1;
            word = 32'h0;
        end
        return word;
    endfunction

    // wishbone slave with random stall and ack delay
    always begin
        @(posedge i_clk);
        #1;
        i_ack = 1'b0;
        if (i_rst) begin
            i_stall   = 1'b0;
            pending   = 1'b0;
            stall_set = 1'b0;
        end else if (pending) begin
            if (ack_wait == 0) begin
                i_ack   = 1'b1;
                i_data  = read_word(req_adr);
                pending = 1'b0;
            end else begin
                ack_wait = ack_wait - 1;
            end
        end else if (o_wb.stb) begin
            if (!stall_set) begin
                stall_left = int'(lcg_next() >> 16) % 4;
                stall_set  = 1'b1;
            end
            if (stall_left > 0) begin
                i_stall    = 1'b1;
                stall_left = stall_left - 1;
            end else begin
                // taken at the coming edge
                i_stall   = 1'b0;
                req_adr   = o_wb.adr;
                ack_wait  = int'(lcg_next() >> 16) % 4;
                pending   = 1'b1;
                stall_set = 1'b0;
            end
        end
    end

    initial begin
        i_rst     = 1'b1;
        i_data    = '0;
        i_ack     = 1'b0;
        i_stall   = 1'b0;
        lcg_state = 32'h6a759d1b;
        load_program();
        for (int i = 0; i < N_ROWS; i++) begin
            mem[exp_rows[i].pc] = words[i];
        end
        repeat (3) @(posedge i_clk);
        #1;
        i_rst = 1'b0;
        while (!done && cycles < MAX_CYCLES) begin
            @(posedge i_clk);
        end
        if (!done) begin
            $display("timeout after %0d cycles with %0d of %0d rows retired",
                     cycles, pass_count + fail_count, N_ROWS);
            timed_out = 1'b1;
        end
        $display("%0d rows passed, %0d rows failed, %0d bus errors, %0d memory errors",
                 pass_count, fail_count, bus_errors, mem_errors);
        if (timed_out || fail_count != 0 || bus_errors != 0 || mem_errors != 0) begin
            $display("TEST RESULT: FAIL");
        end else begin
            $display("TEST RESULT: PASS");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build the testbench with verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_rv32_core \
    -f rv32_mini_core.f -o sim_rv32 > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_rv32 > sim.log 2>&1 || { cat sim.log; echo "simulation aborted"; exit 1; }
cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && exit 1 || exit 0

//--- rv32_mini_core.f
+incdir+common
common/rv32_isa_pkg.sv
common/rv32_bus_pkg.sv
design/rv32_fetch_unit.sv
design/rv32_decoder.sv
design/rv32_execute.sv
design/rv32_regfile.sv
design/rv32_core_top.sv
dv/rv32_core_checker.sv
dv/tb_rv32_core.sv
